//--- Makefile
VERILATOR ?= verilator
TOP       ?= rv_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= ** FAIL **
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q -F '$(FAIL_MSG)' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- filelist.f
+incdir+.
rv_pkg.sv
rv_control.sv
rv_hazard.sv
rv_regfile.sv
rv_alu.sv
rv_imem.sv
rv_dmem.sv
rv_core.sv
tb_clkgen.sv
rv_asserts.sv
rv_tb.sv

//--- rv_alu.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module rv_alu (
    input  rv_pkg::word_t   src_a_i,
    input  rv_pkg::word_t   src_b_i,
    input  rv_pkg::word_t   imm_i,
    input  logic            alu_src_i,
    input  rv_pkg::alu_op_t op_i,
    output rv_pkg::word_t   result_o,
    output logic            eq_o
);

    rv_pkg::word_t opb;

    assign opb = alu_src_i ? imm_i : src_b_i;

    always_comb begin
        case (op_i)
            rv_pkg::ALU_ADD: result_o = src_a_i + opb;
            rv_pkg::ALU_SUB: result_o = src_a_i - opb;
            rv_pkg::ALU_AND: result_o = src_a_i & opb;
            rv_pkg::ALU_OR:  result_o = src_a_i | opb;
            rv_pkg::ALU_SLT: begin
                // signed compare
                result_o = {{(`RV_XLEN-1){1'b0}}, ($signed(src_a_i) < $signed(opb))};
            end
            default:         result_o = src_a_i + opb;
        endcase
    end

    // beq compares the registers and never the immediate
    assign eq_o = (src_a_i == src_b_i);

endmodule

//--- rv_asserts.sv
`timescale 1ns/10ps

module rv_core_asserts (
    input logic              clk_i,
    input logic              reset_i,
    input logic              wb_valid_i,
    input rv_pkg::reg_addr_t wb_rd_i,
    input rv_pkg::word_t     pc_i,
    input logic              stall_f_i,
    input logic              stall_d_i
);

    // one reset edge clears writeback
    a_quiet_in_reset: assert property (@(posedge clk_i) $past(reset_i) |-> !wb_valid_i)
        else $error("retirement strobe high while the core is held in reset");

    a_rd_nonzero: assert property (@(posedge clk_i) wb_valid_i |-> (wb_rd_i != '0))
        else $error("retirement reported for register x0");

    a_pc_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
                                   pc_i[1:0] == 2'b00)
        else $error("fetch address is not word aligned");

    // fetch and decode always hold together
    a_stall_pair: assert property (@(posedge clk_i) stall_f_i == stall_d_i)
        else $error("fetch and decode stalls disagree");

endmodule

bind rv_core rv_core_asserts asserts_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .wb_valid_i (wb_valid_o),
    .wb_rd_i    (wb_rd_o),
    .pc_i       (pc_f),
    .stall_f_i  (stall_f),
    .stall_d_i  (stall_d)
);

//--- rv_control.sv
`timescale 1ns/10ps

module rv_control (
    input  rv_pkg::word_t       instr_i,
    output logic                reg_write_o,
    output rv_pkg::result_src_t result_src_o,
    output logic                mem_write_o,
    output logic                alu_src_o,
    output rv_pkg::alu_op_t     alu_op_o,
    output logic                branch_o,
    output logic                jump_o,
    output rv_pkg::word_t       imm_o
);

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            sub_sel;
    logic            fn_ok;   // funct3 is one we support
    rv_pkg::alu_op_t fn_op;

    assign opcode  = instr_i[6:0];
    assign funct3  = instr_i[14:12];
    assign sub_sel = instr_i[30] && (opcode == OP_REG);  // no subi in the ISA

    // funct3 decode shared by register and immediate forms
    always_comb begin
        fn_ok = 1'b1;
        case (funct3)
            3'b000:  fn_op = sub_sel ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b111:  fn_op = rv_pkg::ALU_AND;
            3'b110:  fn_op = rv_pkg::ALU_OR;
            3'b010:  fn_op = rv_pkg::ALU_SLT;
            default: begin
                fn_op = rv_pkg::ALU_ADD;
                fn_ok = 1'b0;
            end
        endcase
    end

    // control word where anything unknown stays a bubble
    always_comb begin
        reg_write_o  = 1'b0;
        result_src_o = rv_pkg::RES_ALU;
        mem_write_o  = 1'b0;
        alu_src_o    = 1'b0;
        alu_op_o     = rv_pkg::ALU_ADD;
        branch_o     = 1'b0;
        jump_o       = 1'b0;
        case (opcode)
            OP_REG: begin
                reg_write_o = fn_ok;
                alu_op_o    = fn_op;
            end
            OP_IMM: begin
                reg_write_o = fn_ok;
                alu_src_o   = 1'b1;
                alu_op_o    = fn_op;
            end
            OP_LOAD: begin
                reg_write_o  = (funct3 == 3'b010);  // lw only
                result_src_o = rv_pkg::RES_MEM;
                alu_src_o    = 1'b1;
            end
            OP_STORE: begin
                mem_write_o = (funct3 == 3'b010);   // sw only
                alu_src_o   = 1'b1;
            end
            OP_BRANCH: begin
                branch_o = (funct3 == 3'b000);      // beq only
                alu_op_o = rv_pkg::ALU_SUB;
            end
            OP_JAL: begin
                reg_write_o  = 1'b1;
                result_src_o = rv_pkg::RES_PC4;
                jump_o       = 1'b1;
            end
            default: ;
        endcase
    end

    // immediate by format
    always_comb begin
        case (opcode)
            OP_STORE:  imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            OP_BRANCH: imm_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                                instr_i[30:25], instr_i[11:8], 1'b0};
            OP_JAL:    imm_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                                instr_i[20], instr_i[30:21], 1'b0};
            default:   imm_o = {{20{instr_i[31]}}, instr_i[31:20]};  // i-type
        endcase
    end

endmodule

//--- rv_core.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module rv_core (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              imem_we_i,
    input  rv_pkg::word_t     imem_addr_i,
    input  rv_pkg::word_t     imem_data_i,
    output logic              wb_valid_o,
    output rv_pkg::reg_addr_t wb_rd_o,
    output rv_pkg::word_t     wb_data_o
);

    // fetch
    rv_pkg::word_t       pc_f, pc_next_f, instr_f;
    // decode
    rv_pkg::word_t       instr_d, pc_d, imm_d, rd1_d, rd2_d;
    rv_pkg::reg_addr_t   rs1_d, rs2_d, rd_d;
    logic                reg_write_d, mem_write_d, alu_src_d, branch_d, jump_d;
    rv_pkg::result_src_t result_src_d;
    rv_pkg::alu_op_t     alu_op_d;
    // execute
    logic                reg_write_e, mem_write_e, alu_src_e, branch_e, jump_e;
    rv_pkg::result_src_t result_src_e;
    rv_pkg::alu_op_t     alu_op_e;
    rv_pkg::word_t       rd1_e, rd2_e, imm_e, pc_e;
    rv_pkg::reg_addr_t   rs1_e, rs2_e, rd_e;
    rv_pkg::word_t       src_a_e, src_b_e, alu_result_e, target_e, pc_plus4_e;
    rv_pkg::fwd_sel_t    fwd_a_e, fwd_b_e;
    logic                eq_e, taken_e, load_e;
    // memory
    logic                reg_write_m, mem_write_m;
    rv_pkg::result_src_t result_src_m;
    rv_pkg::word_t       alu_result_m, write_data_m, pc_plus4_m, read_data_m;
    rv_pkg::reg_addr_t   rd_m;
    // writeback
    logic                reg_write_w;
    rv_pkg::result_src_t result_src_w;
    rv_pkg::word_t       alu_result_w, read_data_w, pc_plus4_w, result_w;
    rv_pkg::reg_addr_t   rd_w;
    // hazard control
    logic                stall_f, stall_d, flush_d, flush_e;

    // fetch stage
    assign pc_next_f = taken_e ? target_e : pc_f + 32'd4;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_f <= `RV_RESET_PC;
        end else if (!stall_f) begin
            pc_f <= pc_next_f;
        end
    end

    rv_imem imem_i (
        .clk_i   (clk_i),
        .we_i    (imem_we_i && reset_i),   // program load only while held in reset
        .waddr_i (imem_addr_i),
        .wdata_i (imem_data_i),
        .pc_i    (pc_f),
        .instr_o (instr_f)
    );

    // fetch/decode register where a zero word is a bubble
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_d) begin
            instr_d <= '0;
        end else if (!stall_d) begin
            instr_d <= instr_f;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_d) begin
            pc_d <= pc_f;
        end
    end

    // decode stage
    assign rs1_d = instr_d[19:15];
    assign rs2_d = instr_d[24:20];
    assign rd_d  = instr_d[11:7];

    rv_control control_i (
        .instr_i      (instr_d),
        .reg_write_o  (reg_write_d),
        .result_src_o (result_src_d),
        .mem_write_o  (mem_write_d),
        .alu_src_o    (alu_src_d),
        .alu_op_o     (alu_op_d),
        .branch_o     (branch_d),
        .jump_o       (jump_d),
        .imm_o        (imm_d)
    );

    rv_regfile regfile_i (
        .clk_i (clk_i),
        .ra1_i (rs1_d),
        .ra2_i (rs2_d),
        .wa_i  (rd_w),
        .we_i  (reg_write_w),
        .wd_i  (result_w),
        .rd1_o (rd1_d),
        .rd2_o (rd2_d)
    );

    // decode/execute register
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_e) begin
            reg_write_e  <= 1'b0;
            result_src_e <= rv_pkg::RES_ALU;
            mem_write_e  <= 1'b0;
            alu_src_e    <= 1'b0;
            alu_op_e     <= rv_pkg::ALU_ADD;
            branch_e     <= 1'b0;
            jump_e       <= 1'b0;
        end else begin
            reg_write_e  <= reg_write_d;
            result_src_e <= result_src_d;
            mem_write_e  <= mem_write_d;
            alu_src_e    <= alu_src_d;
            alu_op_e     <= alu_op_d;
            branch_e     <= branch_d;
            jump_e       <= jump_d;
        end
    end

    always_ff @(posedge clk_i) begin
        rd1_e <= rd1_d;
        rd2_e <= rd2_d;
        rs1_e <= rs1_d;
        rs2_e <= rs2_d;
        rd_e  <= rd_d;
        imm_e <= imm_d;
        pc_e  <= pc_d;
    end

    // execute stage
    always_comb begin
        case (fwd_a_e)
            rv_pkg::FWD_MEM: src_a_e = alu_result_m;
            rv_pkg::FWD_WB:  src_a_e = result_w;
            default:         src_a_e = rd1_e;
        endcase
        case (fwd_b_e)
            rv_pkg::FWD_MEM: src_b_e = alu_result_m;
            rv_pkg::FWD_WB:  src_b_e = result_w;
            default:         src_b_e = rd2_e;
        endcase
    end

    rv_alu alu_i (
        .src_a_i   (src_a_e),
        .src_b_i   (src_b_e),
        .imm_i     (imm_e),
        .alu_src_i (alu_src_e),
        .op_i      (alu_op_e),
        .result_o  (alu_result_e),
        .eq_o      (eq_e)
    );

    assign taken_e    = (branch_e && eq_e) || jump_e;
    assign target_e   = pc_e + imm_e;        // beq and jal are both pc relative
    assign pc_plus4_e = pc_e + 32'd4;
    assign load_e     = (result_src_e == rv_pkg::RES_MEM);

    rv_hazard hazard_i (
        .rs1_d_i       (rs1_d),
        .rs2_d_i       (rs2_d),
        .rs1_e_i       (rs1_e),
        .rs2_e_i       (rs2_e),
        .rd_e_i        (rd_e),
        .rd_m_i        (rd_m),
        .rd_w_i        (rd_w),
        .reg_write_m_i (reg_write_m),
        .reg_write_w_i (reg_write_w),
        .load_e_i      (load_e),
        .taken_e_i     (taken_e),
        .fwd_a_o       (fwd_a_e),
        .fwd_b_o       (fwd_b_e),
        .stall_f_o     (stall_f),
        .stall_d_o     (stall_d),
        .flush_d_o     (flush_d),
        .flush_e_o     (flush_e)
    );

    // execute/memory register
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            reg_write_m  <= 1'b0;
            result_src_m <= rv_pkg::RES_ALU;
            mem_write_m  <= 1'b0;
        end else begin
            reg_write_m  <= reg_write_e;
            result_src_m <= result_src_e;
            mem_write_m  <= mem_write_e;
        end
    end

    always_ff @(posedge clk_i) begin
        alu_result_m <= alu_result_e;
        write_data_m <= src_b_e;   // store data after forwarding
        rd_m         <= rd_e;
        pc_plus4_m   <= pc_plus4_e;
    end

    // memory stage
    rv_dmem dmem_i (
        .clk_i   (clk_i),
        .we_i    (mem_write_m),
        .addr_i  (alu_result_m),
        .wdata_i (write_data_m),
        .rdata_o (read_data_m)
    );

    // memory/writeback register
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            reg_write_w  <= 1'b0;
            result_src_w <= rv_pkg::RES_ALU;
        end else begin
            reg_write_w  <= reg_write_m;
            result_src_w <= result_src_m;
        end
    end

    always_ff @(posedge clk_i) begin
        alu_result_w <= alu_result_m;
        read_data_w  <= read_data_m;
        rd_w         <= rd_m;
        pc_plus4_w   <= pc_plus4_m;
    end

    // writeback stage
    always_comb begin
        case (result_src_w)
            rv_pkg::RES_MEM: result_w = read_data_w;
            rv_pkg::RES_PC4: result_w = pc_plus4_w;   // jal link value
            default:         result_w = alu_result_w;
        endcase
    end

    // retirement strobe drops x0 writes
    assign wb_valid_o = reg_write_w && (rd_w != '0);
    assign wb_rd_o    = rd_w;
    assign wb_data_o  = result_w;

endmodule

//--- rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// datapath and register file widths
`define RV_XLEN       32
`define RV_REG_AW     5

// memory depths in 32-bit words
`define RV_IMEM_WORDS 256
`define RV_DMEM_WORDS 256

// first fetch address out of reset
`define RV_RESET_PC   32'h0000_0000

`endif

//--- rv_dmem.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module rv_dmem (
    input  logic          clk_i,
    input  logic          we_i,
    input  rv_pkg::word_t addr_i,
    input  rv_pkg::word_t wdata_i,
    output rv_pkg::word_t rdata_o
);

    rv_pkg::word_t mem [`RV_DMEM_WORDS];

    logic [$clog2(`RV_DMEM_WORDS)-1:0] idx;

    assign idx = addr_i[$clog2(`RV_DMEM_WORDS)+1:2];  // word accesses only

    initial begin
        for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[idx] <= wdata_i;
        end
    end

    assign rdata_o = mem[idx];

endmodule

//--- rv_hazard.sv
`timescale 1ns/10ps

module rv_hazard (
    input  rv_pkg::reg_addr_t rs1_d_i,
    input  rv_pkg::reg_addr_t rs2_d_i,
    input  rv_pkg::reg_addr_t rs1_e_i,
    input  rv_pkg::reg_addr_t rs2_e_i,
    input  rv_pkg::reg_addr_t rd_e_i,
    input  rv_pkg::reg_addr_t rd_m_i,
    input  rv_pkg::reg_addr_t rd_w_i,
    input  logic              reg_write_m_i,
    input  logic              reg_write_w_i,
    input  logic              load_e_i,
    input  logic              taken_e_i,
    output rv_pkg::fwd_sel_t  fwd_a_o,
    output rv_pkg::fwd_sel_t  fwd_b_o,
    output logic              stall_f_o,
    output logic              stall_d_o,
    output logic              flush_d_o,
    output logic              flush_e_o
);

    logic hit_m_a, hit_w_a;
    logic hit_m_b, hit_w_b;
    logic load_use;

    // memory stage holds the newer value, so it wins
    assign hit_m_a = reg_write_m_i && (rd_m_i != '0) && (rd_m_i == rs1_e_i);
    assign hit_w_a = reg_write_w_i && (rd_w_i != '0) && (rd_w_i == rs1_e_i);
    assign hit_m_b = reg_write_m_i && (rd_m_i != '0) && (rd_m_i == rs2_e_i);
    assign hit_w_b = reg_write_w_i && (rd_w_i != '0) && (rd_w_i == rs2_e_i);

    assign fwd_a_o = hit_m_a ? rv_pkg::FWD_MEM : (hit_w_a ? rv_pkg::FWD_WB : rv_pkg::FWD_REG);
    assign fwd_b_o = hit_m_b ? rv_pkg::FWD_MEM : (hit_w_b ? rv_pkg::FWD_WB : rv_pkg::FWD_REG);

    // loaded word is not ready until writeback
    assign load_use = load_e_i && (rd_e_i != '0) &&
                      ((rd_e_i == rs1_d_i) || (rd_e_i == rs2_d_i));

    assign stall_f_o = load_use;
    assign stall_d_o = load_use;
    assign flush_d_o = taken_e_i;
    assign flush_e_o = load_use || taken_e_i;  // bubble into execute

endmodule

//--- rv_imem.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module rv_imem (
    input  logic          clk_i,
    input  logic          we_i,
    input  rv_pkg::word_t waddr_i,
    input  rv_pkg::word_t wdata_i,
    input  rv_pkg::word_t pc_i,
    output rv_pkg::word_t instr_o
);

    rv_pkg::word_t mem [`RV_IMEM_WORDS];

    logic [$clog2(`RV_IMEM_WORDS)-1:0] widx;
    logic [$clog2(`RV_IMEM_WORDS)-1:0] ridx;

    assign widx = waddr_i[$clog2(`RV_IMEM_WORDS)-1:0];    // load port is word addressed
    assign ridx = pc_i[$clog2(`RV_IMEM_WORDS)+1:2];       // pc is byte addressed

    // empty words read as zero and decode as bubbles
    initial begin
        for (int i = 0; i < `RV_IMEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[widx] <= wdata_i;
        end
    end

    assign instr_o = mem[ridx];

endmodule

//--- rv_pkg.sv
`include "rv_defs.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0]   word_t;      // data, address, instruction, immediate
    typedef logic [`RV_REG_AW-1:0] reg_addr_t;  // register index

    // alu operation codes
    typedef logic [2:0] alu_op_t;
    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_SLT = 3'd4;

    // writeback source
    typedef logic [1:0] result_src_t;
    localparam result_src_t RES_ALU = 2'd0;
    localparam result_src_t RES_MEM = 2'd1;
    localparam result_src_t RES_PC4 = 2'd2;

    // operand forwarding select
    typedef logic [1:0] fwd_sel_t;
    localparam fwd_sel_t FWD_REG = 2'd0;  // register file value
    localparam fwd_sel_t FWD_WB  = 2'd1;  // writeback result
    localparam fwd_sel_t FWD_MEM = 2'd2;  // alu result in memory stage

endpackage

//--- rv_regfile.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module rv_regfile (
    input  logic              clk_i,
    input  rv_pkg::reg_addr_t ra1_i,
    input  rv_pkg::reg_addr_t ra2_i,
    input  rv_pkg::reg_addr_t wa_i,
    input  logic              we_i,
    input  rv_pkg::word_t     wd_i,
    output rv_pkg::word_t     rd1_o,
    output rv_pkg::word_t     rd2_o
);

    rv_pkg::word_t regs [2**`RV_REG_AW];

    always_ff @(posedge clk_i) begin
        if (we_i && (wa_i != '0)) begin
            regs[wa_i] <= wd_i;
        end
    end

    // writeback value bypasses the array in the same cycle
    assign rd1_o = (ra1_i == '0) ? '0 :
                   (we_i && (wa_i == ra1_i)) ? wd_i : regs[ra1_i];
    assign rd2_o = (ra2_i == '0) ? '0 :
                   (we_i && (wa_i == ra2_i)) ? wd_i : regs[ra2_i];

endmodule

//--- rv_tb.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module rv_tb;

    localparam int PROG_WORDS  = 32;   // every load rewrites this many words
    localparam int RETIRE_WAIT = 200;  // cycles allowed per expected retirement

    // instruction kinds known to the program builder
    localparam int K_ADD  = 0;
    localparam int K_SUB  = 1;
    localparam int K_AND  = 2;
    localparam int K_OR   = 3;
    localparam int K_SLT  = 4;
    localparam int K_ADDI = 5;
    localparam int K_LW   = 6;
    localparam int K_SW   = 7;
    localparam int K_BEQ  = 8;
    localparam int K_JAL  = 9;

    logic              clk;
    logic              gen_reset;
    logic              tb_reset;
    logic              core_reset;
    logic              imem_we;
    rv_pkg::word_t     imem_addr;
    rv_pkg::word_t     imem_data;
    logic              wb_valid;
    rv_pkg::reg_addr_t wb_rd;
    rv_pkg::word_t     wb_data;

    // program image plus the fields the model executes from
    rv_pkg::word_t prog_word [PROG_WORDS];
    int            prog_kind [PROG_WORDS];
    int            prog_rd   [PROG_WORDS];
    int            prog_rs1  [PROG_WORDS];
    int            prog_rs2  [PROG_WORDS];
    rv_pkg::word_t prog_imm  [PROG_WORDS];
    int            prog_len;

    // model state survives between tests just as the core's does
    rv_pkg::word_t     ref_regs [32];
    rv_pkg::word_t     ref_mem  [`RV_DMEM_WORDS];
    rv_pkg::reg_addr_t exp_rd   [$];
    rv_pkg::word_t     exp_data [$];

    logic [15:0] lfsr_state;
    int          error_count;
    int          check_count;
    int          cycle_budget = 50;  // grows as each test starts

    assign core_reset = gen_reset || tb_reset;

    tb_clkgen clkgen_i (
        .clk_o   (clk),
        .reset_o (gen_reset)
    );

    rv_core dut_i (
        .clk_i       (clk),
        .reset_i     (core_reset),
        .imem_we_i   (imem_we),
        .imem_addr_i (imem_addr),
        .imem_data_i (imem_data),
        .wb_valid_o  (wb_valid),
        .wb_rd_o     (wb_rd),
        .wb_data_o   (wb_data)
    );

    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // galois step with taps 16 14 13 11
    endfunction

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    function automatic int rand_imm12();
        logic [31:0] v;
        v = take_bits(12);
        return $signed({{20{v[11]}}, v[11:0]});
    endfunction

    // encode one instruction and keep its fields for the model
    function automatic void emit(int kind, int rd, int rs1, int rs2, int imm);
        logic [31:0]   d, s1, s2, im;
        rv_pkg::word_t w;
        d  = rd;
        s1 = rs1;
        s2 = rs2;
        im = imm;
        case (kind)
            K_ADD:  w = {7'b0000000, s2[4:0], s1[4:0], 3'b000, d[4:0], 7'b0110011};
            K_SUB:  w = {7'b0100000, s2[4:0], s1[4:0], 3'b000, d[4:0], 7'b0110011};
            K_AND:  w = {7'b0000000, s2[4:0], s1[4:0], 3'b111, d[4:0], 7'b0110011};
            K_OR:   w = {7'b0000000, s2[4:0], s1[4:0], 3'b110, d[4:0], 7'b0110011};
            K_SLT:  w = {7'b0000000, s2[4:0], s1[4:0], 3'b010, d[4:0], 7'b0110011};
            K_ADDI: w = {im[11:0], s1[4:0], 3'b000, d[4:0], 7'b0010011};
            K_LW:   w = {im[11:0], s1[4:0], 3'b010, d[4:0], 7'b0000011};
            K_SW:   w = {im[11:5], s2[4:0], s1[4:0], 3'b010, im[4:0], 7'b0100011};
            K_BEQ:  w = {im[12], im[10:5], s2[4:0], s1[4:0], 3'b000, im[4:1], im[11],
                         7'b1100011};
            default: w = {im[20], im[10:1], im[11], im[19:12], d[4:0], 7'b1101111};
        endcase
        prog_word[prog_len] = w;
        prog_kind[prog_len] = kind;
        prog_rd[prog_len]   = rd;
        prog_rs1[prog_len]  = rs1;
        prog_rs2[prog_len]  = rs2;
        prog_imm[prog_len]  = im;
        prog_len++;
    endfunction

    function automatic void retire(int rd, rv_pkg::word_t value);
        if (rd != 0) begin
            ref_regs[rd] = value;
            exp_rd.push_back(rv_pkg::reg_addr_t'(rd));
            exp_data.push_back(value);
        end
    endfunction

    // architectural run of the program in order
    task automatic run_model();
        rv_pkg::word_t pc, pc_next, a, b, imm, addr;
        int            idx, steps, rd;
        pc    = `RV_RESET_PC;
        steps = 0;
        exp_rd.delete();
        exp_data.delete();
        while (steps < 4 * PROG_WORDS) begin
            idx = int'(pc >> 2);
            if (idx >= prog_len) break;
            a       = ref_regs[prog_rs1[idx]];
            b       = ref_regs[prog_rs2[idx]];
            imm     = prog_imm[idx];
            rd      = prog_rd[idx];
            pc_next = pc + 32'd4;
            case (prog_kind[idx])
                K_ADD:  retire(rd, a + b);
                K_SUB:  retire(rd, a - b);
                K_AND:  retire(rd, a & b);
                K_OR:   retire(rd, a | b);
                K_SLT:  retire(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                K_ADDI: retire(rd, a + imm);
                K_LW: begin
                    addr = a + imm;
                    retire(rd, ref_mem[addr[9:2]]);
                end
                K_SW: begin
                    addr = a + imm;
                    ref_mem[addr[9:2]] = b;
                end
                K_BEQ: begin
                    if (a == b) pc_next = pc + imm;
                end
                default: begin  // jal
                    retire(rd, pc + 32'd4);
                    pc_next = pc + imm;
                end
            endcase
            pc = pc_next;
            steps++;
        end
    endtask

    task automatic check_reg(string name, rv_pkg::reg_addr_t expected,
                             rv_pkg::reg_addr_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s: rd expected x%0d, actual x%0d", name, expected, actual);
        end
    endtask

    task automatic check_word(string name, rv_pkg::word_t expected, rv_pkg::word_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s: data expected %h, actual %h", name, expected, actual);
        end
    endtask

    // reset held for the whole load and unused words cleared to bubbles
    task automatic load_program();
        @(posedge clk);
        tb_reset <= 1'b1;
        for (int i = 0; i < PROG_WORDS; i++) begin
            @(posedge clk);
            imem_we   <= 1'b1;
            imem_addr <= i;
            imem_data <= (i < prog_len) ? prog_word[i] : '0;
        end
        @(posedge clk);
        imem_we <= 1'b0;
        repeat (2) @(posedge clk);
        tb_reset <= 1'b0;
    endtask

    task automatic collect(string name);
        int got, waited, limit;
        got    = 0;
        waited = 0;
        limit  = RETIRE_WAIT * exp_rd.size();
        while (got < exp_rd.size() && waited < limit) begin
            @(negedge clk);
            waited++;
            if (wb_valid) begin
                check_reg(name, exp_rd[got], wb_rd);
                check_word(name, exp_data[got], wb_data);
                got++;
            end
        end
        if (got < exp_rd.size()) begin
            error_count++;
            $display("%s: only %0d of %0d register writes retired", name, got, exp_rd.size());
        end
        // flushed or stray instructions would show up here
        repeat (8) begin
            @(negedge clk);
            if (wb_valid) begin
                error_count++;
                $display("%s: unexpected extra retirement to x%0d", name, wb_rd);
            end
        end
    endtask

    task automatic run_program(string name);
        run_model();
        cycle_budget += RETIRE_WAIT * exp_rd.size() + PROG_WORDS + 16;
        load_program();
        collect(name);
    endtask

    task automatic test_alu_chain();
        prog_len = 0;
        emit(K_ADDI, 1, 0, 0, rand_imm12());
        emit(K_ADDI, 2, 0, 0, rand_imm12());
        emit(K_ADD,  3, 1, 2, 0);   // x2 from memory stage and x1 from writeback
        emit(K_SUB,  4, 3, 1, 0);
        emit(K_AND,  5, 4, 3, 0);
        emit(K_OR,   6, 5, 2, 0);
        emit(K_SLT,  7, 6, 1, 0);   // operands differ
        emit(K_SLT,  8, 0, 6, 0);   // sign of x6 decides
        emit(K_ADD,  9, 7, 8, 0);
        run_program("alu_chain");
    endtask

    task automatic test_load_store();
        prog_len = 0;
        emit(K_ADDI, 10, 0, 0, rand_imm12());
        emit(K_ADDI, 11, 0, 0, 16);     // base address
        emit(K_SW,   0, 11, 10, 4);
        emit(K_LW,   12, 11, 0, 4);
        emit(K_ADD,  13, 12, 10, 0);    // load-use stall
        emit(K_SUB,  14, 13, 12, 0);
        emit(K_LW,   15, 0, 0, 20);     // same word through an x0 base
        run_program("load_store");
    endtask

    task automatic test_branches();
        prog_len = 0;
        emit(K_ADDI, 1, 0, 0, rand_imm12());
        emit(K_ADDI, 2, 1, 0, 0);
        emit(K_BEQ,  0, 1, 2, 12);      // taken over x3 and x4
        emit(K_ADDI, 3, 0, 0, 1);
        emit(K_ADDI, 4, 0, 0, 2);
        emit(K_ADDI, 5, 0, 0, 3);
        emit(K_ADDI, 6, 0, 0, 5);
        emit(K_ADDI, 7, 0, 0, 6);
        emit(K_BEQ,  0, 6, 7, 12);      // not taken
        emit(K_ADDI, 8, 0, 0, 7);
        emit(K_ADDI, 9, 0, 0, 8);
        emit(K_ADDI, 10, 0, 0, 9);
        run_program("branches");
    endtask

    task automatic test_jump();
        prog_len = 0;
        emit(K_ADDI, 14, 0, 0, rand_imm12());
        emit(K_JAL,  15, 0, 0, 12);
        emit(K_ADDI, 16, 0, 0, 1);      // flushed
        emit(K_ADDI, 17, 0, 0, 2);
        emit(K_ADDI, 18, 15, 0, 0);     // link read through the bypass
        emit(K_ADD,  19, 18, 14, 0);
        run_program("jump");
    endtask

    task automatic test_x0_writes();
        prog_len = 0;
        emit(K_ADDI, 0, 0, 0, rand_imm12() | 1);
        emit(K_ADD,  20, 0, 0, 0);
        emit(K_ADDI, 21, 0, 0, 7);
        emit(K_ADDI, 0, 21, 0, 5);
        emit(K_OR,   22, 0, 21, 0);     // no forwarding of the x0 write
        emit(K_ADD,  23, 0, 0, 0);
        run_program("x0_writes");
    endtask

    initial begin
        imem_we     = 1'b0;
        imem_addr   = '0;
        imem_data   = '0;
        tb_reset    = 1'b1;
        lfsr_state  = 16'd63;
        error_count = 0;
        check_count = 0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        @(posedge clk);
        wait (gen_reset == 1'b0);
        test_alu_chain();
        test_load_store();
        test_branches();
        test_jump();
        test_x0_writes();
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < cycle_budget) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the core stopped retiring", cycles);
        $display("** FAIL **");
        $finish;
    end

endmodule

//--- tb_clkgen.sv
`timescale 1ns/10ps

module tb_clkgen (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o   = 1'b0;
        reset_o = 1'b1;
        repeat (2) @(posedge clk_o);
        reset_o <= 1'b0;   // two cycles of power-on reset
    end

    always #2 clk_o = ~clk_o;  // 4 ns period

endmodule
